// ==== hdl/noc_wtn_macros.svh ====
`ifndef NOC_WTN_MACROS_SVH
`define NOC_WTN_MACROS_SVH

// ----------------------------------------
// NoC widths
// ----------------------------------------
`define WIDE_NOC_W      256                     // wide side data bits
`define NARROW_NOC_W    64                      // narrow side data bits
`define NUM_ELS         4                       // narrow flits per wide flit

// ----------------------------------------
// header fields
// ----------------------------------------
`define MSG_LEN_W       8                       // body flit count width
`define MSG_LEN_HI      255                     // top bit of length field
`define MSG_LEN_LO      (`MSG_LEN_HI - `MSG_LEN_W + 1)

`endif

// ==== hdl/noc_msg_pkg.sv ====
`include "noc_wtn_macros.svh"

package noc_msg_pkg;

    // ----------------------------------------
    // flit payloads
    // ----------------------------------------

    // one flit on the wide NoC, header or body
    typedef logic [`WIDE_NOC_W-1:0] wide_flit_t;

    // one flit on the narrow NoC
    typedef logic [`NARROW_NOC_W-1:0] narrow_flit_t;

    // ----------------------------------------
    // header fields
    // ----------------------------------------

    // number of body flits behind a header
    typedef logic [`MSG_LEN_W-1:0] msg_len_t;

endpackage

// ==== hdl/wtn_ctrl_pkg.sv ====
`include "noc_wtn_macros.svh"

package wtn_ctrl_pkg;

    // framer position inside a message
    typedef enum logic {
        HDR  = 1'b0,                            // next flit is a header
        BODY = 1'b1                             // body flits still due
    } framer_state_e;

    // narrow element inside a wide flit
    typedef logic [$clog2(`NUM_ELS)-1:0] el_idx_t;

endpackage

// ==== hdl/wtn_stream_if.sv ====
`timescale 1ns/1ps
`include "noc_wtn_macros.svh"

interface wtn_stream_if #(
    parameter int DATA_W = `NARROW_NOC_W
) ();

    logic              val;                     // source has a flit
    logic [DATA_W-1:0] data;
    logic              last;                    // final flit of message
    logic              rdy;                     // sink takes the flit

    // ----------------------------------------
    // views
    // ----------------------------------------
    modport src (
        output val,
        output data,
        output last,
        input  rdy
    );

    modport sink (
        input  val,
        input  data,
        input  last,
        output rdy
    );

endinterface

// ==== hdl/noc_msg_framer.sv ====
`timescale 1ns/1ps
`include "noc_wtn_macros.svh"

module noc_msg_framer
    import noc_msg_pkg::*, wtn_ctrl_pkg::*;
(
    input  logic       clk,
    input  logic       rst,

    input  logic       src_val,
    input  wide_flit_t src_data,
    output logic       src_rdy,

    wtn_stream_if.src  out
);

    framer_state_e state_reg;
    framer_state_e state_next;

    msg_len_t      count_reg;                   // body flits still to come
    msg_len_t      count_next;
    msg_len_t      hdr_len;

    logic          xfer;
    logic          flit_last;

    // ----------------------------------------
    // stream pass-through
    // ----------------------------------------
    assign hdr_len = src_data[`MSG_LEN_HI:`MSG_LEN_LO];
    assign xfer    = src_val & out.rdy;

    assign out.val  = src_val;
    assign out.data = src_data;
    assign out.last = flit_last;
    assign src_rdy  = out.rdy;                  // no storage here

    // ----------------------------------------
    // message tracking
    // ----------------------------------------
    always_comb begin
        state_next = state_reg;
        count_next = count_reg;
        flit_last  = 1'b0;

        case (state_reg)
            HDR: begin
                flit_last = (hdr_len == '0);    // header-only message
                if (xfer && (hdr_len != '0)) begin
                    count_next = hdr_len;
                    state_next = BODY;
                end
            end
            BODY: begin
                flit_last = (count_reg == msg_len_t'(1));
                if (xfer) begin
                    count_next = count_reg - msg_len_t'(1);
                    if (count_reg == msg_len_t'(1)) begin
                        state_next = HDR;
                    end
                end
            end
            default: begin
                state_next = HDR;
            end
        endcase
    end

    always_ff @(posedge clk) begin
        if (rst) begin
            state_reg <= HDR;
            count_reg <= '0;
        end else begin
            state_reg <= state_next;
            count_reg <= count_next;
        end
    end

    // the header length loads the count, so a zero here means
    // a body flit was taken past the message end
    a_body_count_nonzero: assert property (
        @(posedge clk) disable iff (rst)
        (state_reg == BODY) |-> (count_reg != '0)
    ) else $error("framer in BODY with zero count");

endmodule

// ==== hdl/wide_to_narrow.sv ====
`timescale 1ns/1ps
`include "noc_wtn_macros.svh"

module wide_to_narrow
    import noc_msg_pkg::*, wtn_ctrl_pkg::*;
(
    input  logic       clk,
    input  logic       rst,

    wtn_stream_if.sink in,
    wtn_stream_if.src  out
);

    localparam el_idx_t LAST_IDX = el_idx_t'(`NUM_ELS - 1);

    logic       full_reg;                       // holding a wide flit
    el_idx_t    idx_reg;                        // element on the output
    wide_flit_t flit_reg;
    logic       tag_last_reg;                   // flit ends its message

    logic       in_xfer;
    logic       out_xfer;
    logic       el_done;                        // final element leaves

    // ----------------------------------------
    // width checks
    // ----------------------------------------
    if ((`WIDE_NOC_W % `NARROW_NOC_W) != 0) begin : g_bad_ratio
        $error("wide NoC width must be a multiple of the narrow NoC width");
    end

    if (`NARROW_NOC_W < 64) begin : g_bad_narrow
        $error("narrow NoC below 64 bits is not supported");
    end

    if ((`WIDE_NOC_W / `NARROW_NOC_W) != `NUM_ELS) begin : g_bad_els
        $error("NUM_ELS does not match the width ratio");
    end

    // ----------------------------------------
    // handshakes
    // ----------------------------------------
    assign out_xfer = out.val & out.rdy;
    assign el_done  = out_xfer & (idx_reg == LAST_IDX);
    assign in_xfer  = in.val & in.rdy;

    // refill in the cycle the last element goes
    assign in.rdy = ~full_reg | el_done;

    assign out.val  = full_reg;
    assign out.data = flit_reg[idx_reg*`NARROW_NOC_W +: `NARROW_NOC_W];
    assign out.last = tag_last_reg & (idx_reg == LAST_IDX);

    // ----------------------------------------
    // element sequencing
    // ----------------------------------------
    always_ff @(posedge clk) begin
        if (rst) begin
            full_reg <= 1'b0;
            idx_reg  <= '0;
        end else begin
            if (in_xfer) begin
                full_reg <= 1'b1;
                idx_reg  <= '0;                 // restart at low slice
            end else if (el_done) begin
                full_reg <= 1'b0;
            end else if (out_xfer) begin
                idx_reg  <= idx_reg + el_idx_t'(1);
            end
        end
    end

    always_ff @(posedge clk) begin
        if (in_xfer) begin
            flit_reg     <= in.data;
            tag_last_reg <= in.last;
        end
    end

    // a stalled element must not change under the buffer
    a_out_stable: assert property (
        @(posedge clk) disable iff (rst)
        (out.val && !out.rdy) |=> (out.val && $stable(out.data) && $stable(out.last))
    ) else $error("converter output changed while stalled");

endmodule

// ==== hdl/narrow_flit_buffer.sv ====
`timescale 1ns/1ps
`include "noc_wtn_macros.svh"

module narrow_flit_buffer
    import noc_msg_pkg::*;
(
    input  logic         clk,
    input  logic         rst,

    wtn_stream_if.sink   in,

    output logic         val,
    output narrow_flit_t data,
    output logic         last,
    input  logic         rdy
);

    logic         val_reg;                      // main slot full
    narrow_flit_t data_reg;
    logic         last_reg;

    logic         spare_val;                    // skid slot full
    narrow_flit_t spare_data;
    logic         spare_last;

    logic         in_xfer;
    logic         main_free;                    // main slot can load
    logic         spare_load;

    // ----------------------------------------
    // handshake
    // ----------------------------------------
    assign in.rdy     = ~spare_val;             // registered, no path from rdy
    assign in_xfer    = in.val & in.rdy;
    assign main_free  = ~val_reg | rdy;
    assign spare_load = in_xfer & ~main_free;

    assign val  = val_reg;
    assign data = data_reg;
    assign last = last_reg;

    // ----------------------------------------
    // slot control
    // ----------------------------------------
    always_ff @(posedge clk) begin
        if (rst) begin
            val_reg   <= 1'b0;
            spare_val <= 1'b0;
        end else if (main_free) begin
            val_reg   <= spare_val | in_xfer;   // spare drains first
            spare_val <= 1'b0;
        end else if (spare_load) begin
            spare_val <= 1'b1;
        end
    end

    always_ff @(posedge clk) begin
        if (main_free) begin
            if (spare_val) begin
                data_reg <= spare_data;
                last_reg <= spare_last;
            end else if (in_xfer) begin
                data_reg <= in.data;
                last_reg <= in.last;
            end
        end
        if (spare_load) begin
            spare_data <= in.data;
            spare_last <= in.last;
        end
    end

    // a parked flit stays put until the main slot frees
    a_no_overflow: assert property (
        @(posedge clk) disable iff (rst)
        (spare_val && !main_free) |=> (spare_val && $stable(spare_data) && $stable(spare_last))
    ) else $error("full spare slot overwritten");

endmodule

// ==== hdl/noc_wide_to_narrow.sv ====
`timescale 1ns/1ps
`include "noc_wtn_macros.svh"

module noc_wide_to_narrow
    import noc_msg_pkg::*;
(
    input  logic         clk,
    input  logic         rst,

    input  logic         src_val,
    input  wide_flit_t   src_data,
    output logic         src_rdy,

    output logic         dst_val,
    output narrow_flit_t dst_data,
    output logic         dst_last,
    input  logic         dst_rdy
);

    // ----------------------------------------
    // internal streams
    // ----------------------------------------
    wtn_stream_if #(.DATA_W(`WIDE_NOC_W))   wide_if ();   // framer to converter
    wtn_stream_if #(.DATA_W(`NARROW_NOC_W)) narrow_if (); // converter to buffer

    // decode
    noc_msg_framer u_framer (
        .clk      (clk),
        .rst      (rst),
        .src_val  (src_val),
        .src_data (src_data),
        .src_rdy  (src_rdy),
        .out      (wide_if.src)
    );

    // execute
    wide_to_narrow u_converter (
        .clk (clk),
        .rst (rst),
        .in  (wide_if.sink),
        .out (narrow_if.src)
    );

    // result
    narrow_flit_buffer u_buffer (
        .clk  (clk),
        .rst  (rst),
        .in   (narrow_if.sink),
        .val  (dst_val),
        .data (dst_data),
        .last (dst_last),
        .rdy  (dst_rdy)
    );

endmodule

// ==== test/tb_noc_wtn.sv ====
`timescale 1ns/1ps
`include "noc_wtn_macros.svh"

module tb_noc_wtn
    import noc_msg_pkg::*;
();

    localparam int CLK_PERIOD = 100;
    localparam int MAX_TESTS  = 64;
    localparam int SEED       = 32'h6d251938;

    logic         clk;
    logic         rst;
    logic         src_val;
    wide_flit_t   src_data;
    logic         src_rdy;
    logic         dst_val;
    narrow_flit_t dst_data;
    logic         dst_last;
    logic         dst_rdy;

    logic [7:0]   case_mem [0:4*MAX_TESTS-1];   // id, len, gap, stall
    narrow_flit_t exp_data_q[$];
    logic         exp_last_q[$];

    int num_tests;
    int total_narrow;
    int cycle_limit;
    int cycle;
    int data_seed;
    int stall_seed;
    int err_count;
    int pass_count;
    int fail_count;
    int out_test;                               // message now leaving dst
    int first_accept;                           // edge of first wide transfer
    logic rst_done;

    noc_wide_to_narrow DUT (
        .clk      (clk),
        .rst      (rst),
        .src_val  (src_val),
        .src_data (src_data),
        .src_rdy  (src_rdy),
        .dst_val  (dst_val),
        .dst_data (dst_data),
        .dst_last (dst_last),
        .dst_rdy  (dst_rdy)
    );

    initial begin
        clk = 1'b0;
        forever #(CLK_PERIOD/2) clk = ~clk;
    end

    always @(posedge clk) begin
        cycle = cycle + 1;
        if (cycle_limit > 0 && cycle > cycle_limit) begin
            $display("timeout after %0d cycles, %0d of %0d messages done",
                     cycle_limit, out_test, num_tests);
            $display("Test failed");
            $finish;
        end
    end

    // ----------------------------------------
    // source side
    // ----------------------------------------
    task automatic build_flit(input int len, input logic is_hdr, output wide_flit_t flit);
        for (int w = 0; w < `WIDE_NOC_W/32; w++) begin
            flit[w*32 +: 32] = $random(data_seed);
        end
        if (is_hdr) begin
            flit[`MSG_LEN_HI -: `MSG_LEN_W] = len[`MSG_LEN_W-1:0];
        end
    endtask

    task automatic send_flit(input wide_flit_t flit, input int gap, input logic msg_end);
        while (($unsigned($random(data_seed)) % 4) < gap) begin
            src_val = 1'b0;
            @(negedge clk);
        end
        src_val  = 1'b1;
        src_data = flit;
        while (!src_rdy) begin
            @(negedge clk);
        end
        if (first_accept < 0) begin
            first_accept = cycle + 1;           // taken at the coming edge
        end
        for (int s = 0; s < `NUM_ELS; s++) begin
            exp_data_q.push_back(flit[s*`NARROW_NOC_W +: `NARROW_NOC_W]);
            exp_last_q.push_back(msg_end && (s == `NUM_ELS - 1));
        end
        @(negedge clk);
    endtask

    task automatic send_message(input int len, input int gap);
        wide_flit_t flit;
        for (int f = 0; f <= len; f++) begin
            build_flit(len, f == 0, flit);
            send_flit(flit, gap, f == len);
        end
    endtask

    // ----------------------------------------
    // sink side and checks
    // ----------------------------------------
    initial begin : dst_monitor
        logic         hold_pending;
        narrow_flit_t held_data;
        logic         held_last;
        logic         seen_first;
        narrow_flit_t exp_data;
        logic         exp_last;
        int           stall;
        int           len;
        int           rx_count;
        int           err_at_start;

        hold_pending = 1'b0;
        seen_first   = 1'b0;
        rx_count     = 0;
        wait (rst_done);
        err_at_start = err_count;
        forever begin
            @(negedge clk);
            if (hold_pending) begin
                assert (dst_val) else begin
                    $display("dst_val dropped while a flit was stalled in test %0d",
                             out_test);
                    err_count++;
                end
                assert (dst_data == held_data) else begin
                    $display("MISMATCH dst_data under stall: expected %h got %h",
                             held_data, dst_data);
                    err_count++;
                end
                assert (dst_last == held_last) else begin
                    $display("MISMATCH dst_last under stall: expected %h got %h",
                             held_last, dst_last);
                    err_count++;
                end
            end
            if (dst_val && !seen_first) begin
                seen_first = 1'b1;
                assert (first_accept >= 0 && cycle - first_accept <= 2) else begin
                    $display("first narrow flit came %0d cycles after the first wide flit",
                             cycle - first_accept);
                    err_count++;
                end
            end
            stall   = (out_test < num_tests) ? case_mem[4*out_test+3] : 0;
            dst_rdy = (($unsigned($random(stall_seed)) % 4) >= stall);
            hold_pending = dst_val && !dst_rdy;
            held_data    = dst_data;
            held_last    = dst_last;
            if (dst_val && dst_rdy) begin
                assert (exp_data_q.size() > 0) else begin
                    $display("narrow flit %h left dst with nothing expected", dst_data);
                    err_count++;
                end
                if (exp_data_q.size() > 0) begin
                    exp_data = exp_data_q.pop_front();
                    exp_last = exp_last_q.pop_front();
                    rx_count++;
                    assert (dst_data === exp_data) else begin
                        $display("MISMATCH dst_data: expected %h got %h (test %0d flit %0d)",
                                 exp_data, dst_data, out_test, rx_count);
                        err_count++;
                    end
                    assert (dst_last === exp_last) else begin
                        $display("MISMATCH dst_last: expected %h got %h (test %0d flit %0d)",
                                 exp_last, dst_last, out_test, rx_count);
                        err_count++;
                    end
                    if (dst_last) begin                 // message boundary
                        len = case_mem[4*out_test+1];
                        assert (rx_count == 4*(len+1)) else begin
                            $display("message of test %0d gave %0d narrow flits, not %0d",
                                     out_test, rx_count, 4*(len+1));
                            err_count++;
                        end
                        if (err_count == err_at_start) begin
                            pass_count++;
                            $display("test %0h len %0d flits %0d: pass",
                                     case_mem[4*out_test], len, rx_count);
                        end else begin
                            fail_count++;
                            $display("test %0h len %0d flits %0d: FAIL, %0d errors",
                                     case_mem[4*out_test], len, rx_count, err_count - err_at_start);
                        end
                        out_test++;
                        rx_count     = 0;
                        err_at_start = err_count;
                    end
                end
            end
        end
    end

    // ----------------------------------------
    // main sequence
    // ----------------------------------------
    initial begin : main_seq
        rst      = 1'b1;
        src_val  = 1'b0;
        src_data = '0;
        dst_rdy  = 1'b0;
        data_seed    = SEED;
        stall_seed   = ~SEED;                   // own stream for the sink
        err_count    = 0;
        pass_count   = 0;
        fail_count   = 0;
        out_test     = 0;
        cycle        = 0;
        cycle_limit  = 0;
        first_accept = -1;
        rst_done     = 1'b0;

        $readmemh("test/noc_wtn_cases.txt", case_mem);
        num_tests = 0;
        while (num_tests < MAX_TESTS && !$isunknown(case_mem[4*num_tests])) begin
            num_tests++;
        end
        total_narrow = 0;
        for (int t = 0; t < num_tests; t++) begin
            total_narrow += 4*(case_mem[4*t+1] + 1);
        end
        cycle_limit = 8*total_narrow + 100;
        assert (num_tests > 0) else begin
            $display("no test cases could be read from test/noc_wtn_cases.txt");
            err_count++;
        end

        repeat (3) @(posedge clk);
        @(negedge clk);
        rst = 1'b0;
        assert (dst_val === 1'b0) else begin
            $display("MISMATCH dst_val after reset: expected 0 got %h", dst_val);
            err_count++;
        end
        assert (src_rdy === 1'b1) else begin
            $display("MISMATCH src_rdy after reset: expected 1 got %h", src_rdy);
            err_count++;
        end
        rst_done = 1'b1;

        for (int t = 0; t < num_tests; t++) begin
            send_message(case_mem[4*t+1], case_mem[4*t+2]);
        end
        src_val = 1'b0;
        wait (out_test == num_tests);
        repeat (8) @(negedge clk);              // catch stray flits
        assert (exp_data_q.size() == 0) else begin
            $display("%0d expected narrow flits never left dst", exp_data_q.size());
            err_count++;
        end

        $display("tests passed %0d failed %0d, errors %0d", pass_count, fail_count, err_count);
        if (err_count == 0 && fail_count == 0) begin
            $display("Test completed successfully");
        end else begin
            $display("Test failed");
        end
        $finish;
    end

endmodule

// ==== src.f ====
+incdir+hdl
hdl/noc_msg_pkg.sv
hdl/wtn_ctrl_pkg.sv
hdl/wtn_stream_if.sv
hdl/noc_msg_framer.sv
hdl/wide_to_narrow.sv
hdl/narrow_flit_buffer.sv
hdl/noc_wide_to_narrow.sv
test/tb_noc_wtn.sv

// ==== test/noc_wtn_cases.txt ====
// columns: test id, body length (0 to c), source gap and sink stall in quarters
// all values hex, one message per line, messages run back to back
00 0 0 0
01 1 0 0
02 2 0 0
03 0 0 0
04 c 0 0
05 3 0 0
06 0 0 2
07 4 0 1
08 5 0 2
09 1 0 3
0a 0 1 0
0b 6 2 0
0c 7 3 0
0d 2 1 1
0e 8 2 2
0f 0 3 1
10 a 1 2
11 b 2 1
12 c 1 1
13 9 0 0
14 0 0 0
15 4 2 3
16 1 3 3
17 c 0 0
18 3 1 0
19 6 0 1
